// File: common/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  aluOp_t;

    // alu operation codes
    localparam aluOp_t ALU_ADD = 4'h0;
    localparam aluOp_t ALU_SUB = 4'h1;
    localparam aluOp_t ALU_AND = 4'h2;
    localparam aluOp_t ALU_OR  = 4'h3;
    localparam aluOp_t ALU_SLT = 4'h4;
    localparam aluOp_t ALU_SLL = 4'h5;
    localparam aluOp_t ALU_SRL = 4'h6;
    localparam aluOp_t ALU_LUI = 4'h7; // b[15:0] into the upper half

    // major opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // r-type function field
    localparam funct_t FN_SLL = 6'h00;
    localparam funct_t FN_SRL = 6'h02;
    localparam funct_t FN_JR  = 6'h08;
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    // first fetch address after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    localparam regAddr_t LINK_REG = 5'd31; // jal destination

endpackage

`default_nettype wire

// File: common/stageBus.sv
`timescale 1ns/1ps
`default_nettype none

// decode to execute
interface idExBus;
    import mipsPkg::*;

    word_t    operandA;
    word_t    operandB;
    word_t    imm;
    logic [4:0] shamt;
    regAddr_t destAddr;
    aluOp_t   aluOp;
    logic     useImm;
    logic     useShamt;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;

    modport driver (output operandA, operandB, imm, shamt, destAddr, aluOp,
                    useImm, useShamt, regWrite, memRead, memWrite);
    modport receiver (input operandA, operandB, imm, shamt, destAddr, aluOp,
                      useImm, useShamt, regWrite, memRead, memWrite);
endinterface

// execute to memory
interface exMemBus;
    import mipsPkg::*;

    word_t    aluResult;
    word_t    storeData;  // rt value for sw
    regAddr_t destAddr;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;

    modport driver (output aluResult, storeData, destAddr,
                    regWrite, memRead, memWrite);
    modport receiver (input aluResult, storeData, destAddr,
                      regWrite, memRead, memWrite);
endinterface

`default_nettype wire

// File: decode/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::regAddr_t rsAddr,
    input  mipsPkg::regAddr_t rtAddr,
    output mipsPkg::word_t    rsData,
    output mipsPkg::word_t    rtData,
    input  logic              wrEn,
    input  mipsPkg::regAddr_t wrAddr,
    input  mipsPkg::word_t    wrData
);
    import mipsPkg::*;

    word_t regs [0:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // same-cycle write shows through
    assign rsData = (rsAddr == '0) ? '0 :
                    (wrEn && wrAddr == rsAddr) ? wrData : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (wrEn && wrAddr == rtAddr) ? wrData : regs[rtAddr];

    // decode drops every write aimed at $0
    zeroRegFixed: assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0);

endmodule

`default_nettype wire

// File: decode/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  mipsPkg::word_t    instr,
    input  logic              exWrite,
    input  mipsPkg::regAddr_t exDest,
    input  logic              memWrite,
    input  mipsPkg::regAddr_t memDest,
    input  logic              rsEqualRt,
    output mipsPkg::aluOp_t   aluOp,
    output logic              regWrite,
    output logic              memRead,
    output logic              memStore,
    output logic              useImm,
    output logic              useShamt,
    output logic              zeroExtend,
    output logic              writeToRd,
    output logic              isJal,
    output logic              isJump,
    output logic              isJumpReg,
    output logic              taken,
    output logic              stall
);
    import mipsPkg::*;

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rs;
    regAddr_t rt;
    logic     usesRs, usesRt;
    logic     branchHit;
    logic     rsHazard, rtHazard;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    always_comb begin
        aluOp      = ALU_ADD;
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memStore   = 1'b0;
        useImm     = 1'b0;
        useShamt   = 1'b0;
        zeroExtend = 1'b0;
        writeToRd  = 1'b0;
        isJal      = 1'b0;
        isJump     = 1'b0;
        isJumpReg  = 1'b0;
        branchHit  = 1'b0;
        usesRs     = 1'b0;
        usesRt     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                regWrite  = 1'b1;
                writeToRd = 1'b1;
                usesRs    = 1'b1;
                usesRt    = 1'b1;
                case (funct)
                    FN_ADD: aluOp = ALU_ADD;
                    FN_SUB: aluOp = ALU_SUB;
                    FN_AND: aluOp = ALU_AND;
                    FN_OR:  aluOp = ALU_OR;
                    FN_SLT: aluOp = ALU_SLT;
                    FN_SLL: begin aluOp = ALU_SLL; useShamt = 1'b1; usesRs = 1'b0; end
                    FN_SRL: begin aluOp = ALU_SRL; useShamt = 1'b1; usesRs = 1'b0; end
                    FN_JR:  begin regWrite = 1'b0; usesRt = 1'b0; isJumpReg = 1'b1; end
                    default: begin regWrite = 1'b0; usesRs = 1'b0; usesRt = 1'b0; end
                endcase
            end
            OP_ADDI: begin regWrite = 1'b1; useImm = 1'b1; usesRs = 1'b1; end
            OP_ANDI: begin
                aluOp = ALU_AND; regWrite = 1'b1; useImm = 1'b1; zeroExtend = 1'b1; usesRs = 1'b1;
            end
            OP_ORI: begin
                aluOp = ALU_OR; regWrite = 1'b1; useImm = 1'b1; zeroExtend = 1'b1; usesRs = 1'b1;
            end
            OP_LUI: begin aluOp = ALU_LUI; regWrite = 1'b1; useImm = 1'b1; end
            OP_LW: begin regWrite = 1'b1; memRead = 1'b1; useImm = 1'b1; usesRs = 1'b1; end
            OP_SW: begin memStore = 1'b1; useImm = 1'b1; usesRs = 1'b1; usesRt = 1'b1; end
            OP_BEQ: begin branchHit = rsEqualRt; usesRs = 1'b1; usesRt = 1'b1; end
            OP_BNE: begin branchHit = !rsEqualRt; usesRs = 1'b1; usesRt = 1'b1; end
            OP_J:   isJump = 1'b1;
            OP_JAL: begin isJump = 1'b1; isJal = 1'b1; regWrite = 1'b1; end
            default: ; // unknown opcode runs as a nop
        endcase
    end

    // raw hazard against ex and mem, wb is covered by the regfile bypass
    assign rsHazard = usesRs && (rs != '0) &&
                      ((exWrite && exDest == rs) || (memWrite && memDest == rs));
    assign rtHazard = usesRt && (rt != '0) &&
                      ((exWrite && exDest == rt) || (memWrite && memDest == rt));
    assign stall    = rsHazard || rtHazard;

    assign taken = !stall && (isJump || isJumpReg || branchHit);

endmodule

`default_nettype wire

// File: decode/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic              clk,
    input  logic              arstN,
    input  mipsPkg::word_t    pc,
    input  mipsPkg::word_t    instr,
    input  logic              wbEn,
    input  mipsPkg::regAddr_t wbAddr,
    input  mipsPkg::word_t    wbData,
    input  logic              exWrite,
    input  logic              memWrite,
    input  mipsPkg::regAddr_t exDest,
    input  mipsPkg::regAddr_t memDest,
    output logic              taken,
    output mipsPkg::word_t    target,
    output logic              stall,
    idExBus.driver            idEx
);
    import mipsPkg::*;

    word_t    rsData;
    word_t    rtData;
    word_t    imm;
    word_t    pcPlus4;
    word_t    linkAddr;
    word_t    branchTarget;
    word_t    jumpTarget;
    regAddr_t destAddr;
    aluOp_t   aluOp;
    logic     rsEqualRt;
    logic     regWrite;
    logic     memRead;
    logic     memStore;
    logic     useImm;
    logic     useShamt;
    logic     zeroExtend;
    logic     writeToRd;
    logic     isJal;
    logic     isJump;
    logic     isJumpReg;
    logic     destWrite;

    controlUnit ctrl (
        .instr(instr), .exWrite(exWrite), .exDest(exDest),
        .memWrite(memWrite), .memDest(memDest), .rsEqualRt(rsEqualRt),
        .aluOp(aluOp), .regWrite(regWrite), .memRead(memRead), .memStore(memStore),
        .useImm(useImm), .useShamt(useShamt), .zeroExtend(zeroExtend),
        .writeToRd(writeToRd), .isJal(isJal), .isJump(isJump),
        .isJumpReg(isJumpReg), .taken(taken), .stall(stall)
    );

    regFile regs (
        .clk(clk), .arstN(arstN),
        .rsAddr(instr[25:21]), .rtAddr(instr[20:16]),
        .rsData(rsData), .rtData(rtData),
        .wrEn(wbEn), .wrAddr(wbAddr), .wrData(wbData)
    );

    assign rsEqualRt = rsData == rtData;

    assign imm = zeroExtend ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    assign destAddr  = isJal ? LINK_REG : (writeToRd ? instr[15:11] : instr[20:16]);
    assign destWrite = regWrite && (destAddr != '0); // writes to $0 vanish here

    assign pcPlus4      = pc + 32'd4;
    assign linkAddr     = pc + 32'd8;  // skips the delay slot
    assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};
    assign target       = isJumpReg ? rsData : (isJump ? jumpTarget : branchTarget);

    // bubble on stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
        end else begin
            idEx.regWrite <= destWrite && !stall;
            idEx.memRead  <= memRead && !stall;
            idEx.memWrite <= memStore && !stall;
        end
    end

    always_ff @(posedge clk) begin
        idEx.operandA <= isJal ? linkAddr : rsData;
        idEx.operandB <= isJal ? '0 : rtData;
        idEx.imm      <= imm;
        idEx.shamt    <= instr[10:6];
        idEx.destAddr <= destAddr;
        idEx.aluOp    <= aluOp;
        idEx.useImm   <= useImm;
        idEx.useShamt <= useShamt;
    end

    // a producer reaches wb within two cycles
    stallBound: assert property (@(posedge clk) disable iff (!arstN)
        stall ##1 stall |=> !stall);

endmodule

`default_nettype wire

// File: src/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic           clk,
    input  logic           arstN,
    input  logic           stall,
    input  logic           taken,
    input  mipsPkg::word_t target,
    output mipsPkg::word_t imemAddr,
    input  mipsPkg::word_t imemData,
    output mipsPkg::word_t pc,
    output mipsPkg::word_t instr
);
    import mipsPkg::*;

    word_t pcReg;
    word_t nextPc;

    assign nextPc   = taken ? target : pcReg + 32'd4;
    assign imemAddr = pcReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg <= RESET_PC;
            instr <= '0;    // nop in IF/ID
        end else if (!stall) begin
            pcReg <= nextPc;
            instr <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) pc <= pcReg;
    end

    // jr is the only way in for a bad address
    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pcReg[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic              clk,
    input  logic              arstN,
    idExBus.receiver          idEx,
    exMemBus.driver           exMem,
    output logic              exWrite,
    output mipsPkg::regAddr_t exDest
);
    import mipsPkg::*;

    word_t aluA;
    word_t aluB;
    word_t aluResult;

    assign aluA = idEx.useShamt ? {27'd0, idEx.shamt} : idEx.operandA;
    assign aluB = idEx.useImm ? idEx.imm : idEx.operandB;

    always_comb begin
        case (idEx.aluOp)
            ALU_ADD: aluResult = aluA + aluB;
            ALU_SUB: aluResult = aluA - aluB;
            ALU_AND: aluResult = aluA & aluB;
            ALU_OR:  aluResult = aluA | aluB;
            ALU_SLT: aluResult = {31'd0, $signed(aluA) < $signed(aluB)};
            ALU_SLL: aluResult = aluB << aluA[4:0];  // shifts act on rt
            ALU_SRL: aluResult = aluB >> aluA[4:0];
            ALU_LUI: aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = aluA + aluB;
        endcase
    end

    // for the decode hazard check
    assign exWrite = idEx.regWrite;
    assign exDest  = idEx.destAddr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem.regWrite <= 1'b0;
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
        end else begin
            exMem.regWrite <= idEx.regWrite;
            exMem.memRead  <= idEx.memRead;
            exMem.memWrite <= idEx.memWrite;
        end
    end

    always_ff @(posedge clk) begin
        exMem.aluResult <= aluResult;
        exMem.storeData <= idEx.operandB;
        exMem.destAddr  <= idEx.destAddr;
    end

endmodule

`default_nettype wire

// File: src/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  logic              clk,
    input  logic              arstN,
    exMemBus.receiver         exMem,
    output mipsPkg::word_t    dmemAddr,
    output mipsPkg::word_t    dmemWrData,
    output logic              dmemWrEn,
    input  mipsPkg::word_t    dmemRdData,
    output logic              memWrite,
    output mipsPkg::regAddr_t memDest,
    output logic              wbEn,
    output mipsPkg::regAddr_t wbAddr,
    output mipsPkg::word_t    wbData
);
    import mipsPkg::*;

    word_t resultData;

    assign dmemAddr   = exMem.aluResult;
    assign dmemWrData = exMem.storeData;
    assign dmemWrEn   = exMem.memWrite;
    assign memWrite   = exMem.regWrite;  // register write pending in mem
    assign memDest    = exMem.destAddr;
    assign resultData = exMem.memRead ? dmemRdData : exMem.aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) wbEn <= 1'b0;
        else        wbEn <= exMem.regWrite;
    end

    always_ff @(posedge clk) begin
        wbAddr <= exMem.destAddr;
        wbData <= resultData;
    end

    noLoadStore: assert property (@(posedge clk) disable iff (!arstN)
        !(exMem.memRead && exMem.memWrite));

endmodule

`default_nettype wire

// File: src/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  logic              clk,
    input  logic              arstN,
    output mipsPkg::word_t    imemAddr,
    input  mipsPkg::word_t    imemData,
    output mipsPkg::word_t    dmemAddr,
    output mipsPkg::word_t    dmemWrData,
    output logic              dmemWrEn,
    input  mipsPkg::word_t    dmemRdData,
    output logic              wbEn,
    output mipsPkg::regAddr_t wbAddr,
    output mipsPkg::word_t    wbData
);
    import mipsPkg::*;

    word_t    ifPc;
    word_t    ifInstr;
    word_t    target;
    logic     taken;
    logic     stall;
    logic     exWrite;
    logic     memWrite;
    regAddr_t exDest;
    regAddr_t memDest;

    idExBus  idEx ();
    exMemBus exMem ();

    fetchStage fetch (
        .clk(clk), .arstN(arstN), .stall(stall), .taken(taken), .target(target),
        .imemAddr(imemAddr), .imemData(imemData), .pc(ifPc), .instr(ifInstr)
    );

    decodeStage decode (
        .clk(clk), .arstN(arstN), .pc(ifPc), .instr(ifInstr),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .exWrite(exWrite), .memWrite(memWrite), .exDest(exDest), .memDest(memDest),
        .taken(taken), .target(target), .stall(stall), .idEx(idEx)
    );

    executeStage execute (
        .clk(clk), .arstN(arstN), .idEx(idEx), .exMem(exMem),
        .exWrite(exWrite), .exDest(exDest)
    );

    memoryStage memory (
        .clk(clk), .arstN(arstN), .exMem(exMem),
        .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrEn(dmemWrEn),
        .dmemRdData(dmemRdData), .memWrite(memWrite), .memDest(memDest),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

endmodule

`default_nettype wire

// File: bench/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// data memory contents before each program
function automatic word_t presetWord(input int idx);
    return (word_t'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
endfunction

// walks progMem one instruction at a time, delay slot included
function automatic void runReference();
    word_t    regs [32];
    word_t    mem [256];
    word_t    pcNow;
    word_t    pcNext;
    word_t    pcAfter;
    word_t    instr;
    word_t    a;
    word_t    b;
    word_t    sext;
    word_t    res;
    regAddr_t rd;
    logic     wr;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < 256; i++) mem[i] = presetWord(i);
    expWrAddr.delete();
    expWrData.delete();
    expStAddr.delete();
    expStData.delete();
    pcNow = RESET_PC;
    pcNext = RESET_PC + 32'd4;
    for (int step = 0; step < 4000; step++) begin
        instr = progMem[pcNow[9:2]];
        a = regs[instr[25:21]];
        b = regs[instr[20:16]];
        sext = {{16{instr[15]}}, instr[15:0]};
        pcAfter = pcNext + 32'd4;
        rd = instr[20:16];
        wr = 1'b1;
        res = a + sext;  // also the lw and sw address
        case (instr[31:26])
            OP_RTYPE: begin
                rd = instr[15:11];
                case (instr[5:0])
                    FN_ADD: res = a + b;
                    FN_SUB: res = a - b;
                    FN_AND: res = a & b;
                    FN_OR:  res = a | b;
                    FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
                    FN_SLL: res = b << instr[10:6];
                    FN_SRL: res = b >> instr[10:6];
                    FN_JR: begin
                        wr = 1'b0;
                        pcAfter = a;
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDI: res = a + sext;
            OP_ANDI: res = a & {16'h0000, instr[15:0]};
            OP_ORI:  res = a | {16'h0000, instr[15:0]};
            OP_LUI:  res = {instr[15:0], 16'h0000};
            OP_LW:   res = mem[res[9:2]];
            OP_SW: begin
                wr = 1'b0;
                mem[res[9:2]] = b;
                expStAddr.push_back(res);
                expStData.push_back(b);
            end
            OP_BEQ, OP_BNE: begin
                wr = 1'b0;
                if ((a == b) == (instr[31:26] == OP_BEQ)) pcAfter = pcNow + 32'd4 + (sext << 2);
            end
            OP_J, OP_JAL: begin
                pcAfter = {pcNext[31:28], instr[25:0], 2'b00};
                if (pcAfter == pcNow) return;  // jump to itself ends the program
                wr = (instr[31:26] == OP_JAL);
                rd = LINK_REG;
                res = pcNow + 32'd8;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != '0) begin
            regs[rd] = res;
            expWrAddr.push_back(rd);
            expWrData.push_back(res);
        end
        pcNow = pcNext;
        pcNext = pcAfter;
    end
endfunction

`endif

// File: bench/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;
    import mipsPkg::*;

    logic     clk;
    logic     arstN;
    word_t    imemAddr;
    word_t    imemData;
    word_t    dmemAddr;
    word_t    dmemWrData;
    logic     dmemWrEn;
    word_t    dmemRdData;
    logic     wbEn;
    regAddr_t wbAddr;
    word_t    wbData;

    word_t    progMem [256];
    word_t    dataMem [256];
    word_t    prog [$];
    regAddr_t expWrAddr [$];
    word_t    expWrData [$];
    word_t    expStAddr [$];
    word_t    expStData [$];
    int       wrIdx;
    int       stIdx;
    int       valueErrors;
    int       otherErrors;
    integer   seed;
    logic     resetTail;  // first cycle out of reset

    `include "refModel.svh"

    mipsCore DUT (
        .clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrEn(dmemWrEn),
        .dmemRdData(dmemRdData), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    assign imemData   = progMem[imemAddr[9:2]];
    assign dmemRdData = dataMem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (!arstN) begin
            for (int i = 0; i < 256; i++) dataMem[i] <= presetWord(i);
        end else if (dmemWrEn) begin
            dataMem[dmemAddr[9:2]] <= dmemWrData;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compareAddr(input string name, input regAddr_t expected,
                               input regAddr_t actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compareWord(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            valueErrors++;
            $display("Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    function automatic word_t rType(funct_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                    logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic appendHaltLoop();
        prog.push_back({OP_J, 26'(prog.size())});
        prog.push_back('0);  // delay slot
    endtask

    task automatic buildRandomProgram(input int count);
        int          kind;
        regAddr_t    rs;
        regAddr_t    rt;
        regAddr_t    rd;
        logic [15:0] imm;
        prog.delete();
        for (int i = 0; i < count; i++) begin
            kind = ($random(seed) & 32'h7fff_ffff) % 11;
            rs = regAddr_t'($random(seed) & 7);  // few registers for close dependencies
            rt = regAddr_t'($random(seed) & 7);
            rd = regAddr_t'($random(seed) & 7);
            imm = 16'($random(seed));
            case (kind)
                0: prog.push_back(rType(FN_ADD, rs, rt, rd, 5'd0));
                1: prog.push_back(rType(FN_SUB, rs, rt, rd, 5'd0));
                2: prog.push_back(rType(FN_AND, rs, rt, rd, 5'd0));
                3: prog.push_back(rType(FN_OR, rs, rt, rd, 5'd0));
                4: prog.push_back(rType(FN_SLT, rs, rt, rd, 5'd0));
                5: prog.push_back(rType(FN_SLL, 5'd0, rt, rd, imm[4:0]));
                6: prog.push_back(rType(FN_SRL, 5'd0, rt, rd, imm[4:0]));
                7: prog.push_back(iType(OP_ADDI, rs, rd, imm));
                8: prog.push_back(iType(OP_ANDI, rs, rd, imm));
                9: prog.push_back(iType(OP_ORI, rs, rd, imm));
                default: prog.push_back(iType(OP_LUI, 5'd0, rd, imm));
            endcase
        end
        appendHaltLoop();
    endtask

    task automatic buildControlProgram();
        prog.delete();
        prog.push_back(iType(OP_ORI, 5'd0, 5'd1, 16'h0040));    // base address
        prog.push_back(iType(OP_LW, 5'd1, 5'd2, 16'h0000));     // preset word
        prog.push_back(iType(OP_ADDI, 5'd2, 5'd3, 16'h0005));   // load then use
        prog.push_back(iType(OP_SW, 5'd1, 5'd3, 16'h0004));
        prog.push_back(iType(OP_LW, 5'd1, 5'd4, 16'h0004));     // stored word back
        prog.push_back(rType(FN_ADD, 5'd4, 5'd2, 5'd5, 5'd0));
        prog.push_back(iType(OP_SW, 5'd1, 5'd5, 16'hfff8));
        prog.push_back(iType(OP_BEQ, 5'd2, 5'd2, 16'd2));       // taken
        prog.push_back(iType(OP_ADDI, 5'd0, 5'd6, 16'd1));
        prog.push_back(iType(OP_ADDI, 5'd0, 5'd6, 16'd99));     // skipped
        prog.push_back(iType(OP_BNE, 5'd6, 5'd6, 16'd2));       // not taken
        prog.push_back(iType(OP_ADDI, 5'd0, 5'd7, 16'd2));
        prog.push_back(iType(OP_ADDI, 5'd7, 5'd7, 16'd3));
        prog.push_back(iType(OP_BNE, 5'd7, 5'd0, 16'd2));       // taken
        prog.push_back(iType(OP_ADDI, 5'd0, 5'd8, 16'd4));
        prog.push_back(iType(OP_ADDI, 5'd0, 5'd8, 16'd77));
        prog.push_back(iType(OP_BEQ, 5'd7, 5'd0, 16'd2));       // not taken
        prog.push_back(iType(OP_ADDI, 5'd0, 5'd0, 16'd9));      // $0 stays zero
        prog.push_back({OP_JAL, 26'd40});
        prog.push_back(rType(FN_OR, 5'd0, 5'd8, 5'd9, 5'd0));
        prog.push_back(iType(OP_SW, 5'd1, LINK_REG, 16'h000c));
        prog.push_back(rType(FN_ADD, 5'd0, 5'd0, 5'd10, 5'd0));
        prog.push_back({OP_J, 26'd25});
        prog.push_back(iType(OP_ADDI, 5'd0, 5'd13, 16'd6));     // delay slot of j
        prog.push_back(iType(OP_ADDI, 5'd0, 5'd13, 16'd55));    // skipped
        appendHaltLoop();
        while (prog.size() < 40) prog.push_back('0);
        // subroutine at 0xa0
        prog.push_back(iType(OP_ADDI, LINK_REG, 5'd11, 16'd1));
        prog.push_back(rType(FN_JR, LINK_REG, 5'd0, 5'd0, 5'd0));
        prog.push_back(rType(FN_SLL, 5'd0, 5'd11, 5'd12, 5'd2));
    endtask

    task automatic runProgram(input string name);
        int cycles;
        @(posedge clk);
        #1;
        arstN = 1'b0;
        for (int i = 0; i < 256; i++) progMem[i] = (i < prog.size()) ? prog[i] : '0;
        runReference();
        wrIdx = 0;
        stIdx = 0;
        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;
        compareWord("imemAddr", RESET_PC, imemAddr);
        cycles = 0;
        while ((wrIdx < expWrAddr.size() || stIdx < expStAddr.size()) && cycles < 3000) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= 3000) begin
            otherErrors++;
            $display("timeout in program %s: %0d of %0d register writes, %0d of %0d stores",
                     name, wrIdx, expWrAddr.size(), stIdx, expStAddr.size());
        end
        repeat (10) @(posedge clk);  // room for stray strobes
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!arstN || resetTail) begin
            if (wbEn || dmemWrEn) begin
                otherErrors++;
                $display("a write strobe was raised during reset or in the first cycle after it");
            end
        end else begin
            if (wbEn) begin
                if (wrIdx >= expWrAddr.size()) begin
                    otherErrors++;
                    $display("register write to %0d came after the last expected one", wbAddr);
                end else begin
                    compareAddr("wbAddr", expWrAddr[wrIdx], wbAddr);
                    compareWord("wbData", expWrData[wrIdx], wbData);
                    wrIdx++;
                end
            end
            if (dmemWrEn) begin
                if (stIdx >= expStAddr.size()) begin
                    otherErrors++;
                    $display("store to %h came after the last expected one", dmemAddr);
                end else begin
                    compareWord("dmemAddr", expStAddr[stIdx], dmemAddr);
                    compareWord("dmemWrData", expStData[stIdx], dmemWrData);
                    stIdx++;
                end
            end
        end
        resetTail = !arstN;
    end

    initial begin
        arstN = 1'b0;
        seed = 16;
        valueErrors = 0;
        otherErrors = 0;
        wrIdx = 0;
        stIdx = 0;
        resetTail = 1'b1;
        for (int i = 0; i < 256; i++) progMem[i] = '0;
        buildRandomProgram(80);
        runProgram("random arithmetic");
        buildRandomProgram(80);
        runProgram("second random arithmetic");
        buildControlProgram();
        runProgram("memory and control flow");
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+bench
common/mipsPkg.sv
common/stageBus.sv
decode/regFile.sv
decode/controlUnit.sv
decode/decodeStage.sv
src/fetchStage.sv
src/executeStage.sv
src/memoryStage.sv
src/mipsCore.sv
bench/coreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= coreTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation passed

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory $(OBJ_DIR)"
	@echo "make help   show this list"
	@echo "overridable: VERILATOR TOP OBJ_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
